// File: src/wb_pkg.sv
`default_nettype none

package wb_pkg;

        // ------------------------------------------------------------------
        // Widths.
        // ------------------------------------------------------------------

        localparam int DATA_W    = 32;
        localparam int PHY_REGS  = 46;
        localparam int PHY_IDX_W = 6;

        typedef logic [PHY_IDX_W-1:0] phy_idx_t;
        typedef logic [DATA_W-1:0]    word_t;

        // Exception vectors.
        localparam word_t RESET_VECTOR = 32'h0000_0000;
        localparam word_t UND_VECTOR   = 32'h0000_0004;
        localparam word_t SWI_VECTOR   = 32'h0000_0008;
        localparam word_t PABT_VECTOR  = 32'h0000_000C;
        localparam word_t DABT_VECTOR  = 32'h0000_0010;
        localparam word_t IRQ_VECTOR   = 32'h0000_0018;
        localparam word_t FIQ_VECTOR   = 32'h0000_001C;

        // ------------------------------------------------------------------
        // CPSR layout.
        // ------------------------------------------------------------------

        localparam int I_BIT   = 7;
        localparam int F_BIT   = 6;
        localparam int MODE_HI = 4;
        localparam int MODE_LO = 0;

        localparam logic [4:0] MODE_FIQ = 5'h11;
        localparam logic [4:0] MODE_IRQ = 5'h12;
        localparam logic [4:0] MODE_SVC = 5'h13;
        localparam logic [4:0] MODE_ABT = 5'h17;
        localparam logic [4:0] MODE_UND = 5'h1B;

        // Supervisor mode, IRQ and FIQ masked.
        localparam word_t CPSR_INIT = 32'h0000_00D3;

        // Physical register map. 0 to 15 are the user registers.
        localparam phy_idx_t ARCH_PC      = 6'd15;
        localparam phy_idx_t PHY_RAZ      = 6'd16;
        localparam phy_idx_t PHY_FIQ_R14  = 6'd24;
        localparam phy_idx_t PHY_FIQ_SPSR = 6'd25;
        localparam phy_idx_t PHY_IRQ_R14  = 6'd27;
        localparam phy_idx_t PHY_IRQ_SPSR = 6'd28;
        localparam phy_idx_t PHY_SVC_R14  = 6'd30;
        localparam phy_idx_t PHY_SVC_SPSR = 6'd31;
        localparam phy_idx_t PHY_UND_R14  = 6'd33;
        localparam phy_idx_t PHY_UND_SPSR = 6'd34;
        localparam phy_idx_t PHY_ABT_R14  = 6'd36;
        localparam phy_idx_t PHY_ABT_SPSR = 6'd37;

        // ------------------------------------------------------------------
        // Shared structs.
        // ------------------------------------------------------------------

        typedef struct packed {
                logic     en;
                phy_idx_t idx_a;
                word_t    data_a;
                phy_idx_t idx_b;
                word_t    data_b;
                logic     cpsr_en;
                word_t    cpsr;
        } rf_wr_req_t;

        typedef struct packed {
                logic  valid;
                word_t pc;
        } redirect_t;

        typedef struct packed {
                logic  valid;
                word_t pc;
        } pc_slot_t;

endpackage

`default_nettype wire

// File: src/exception_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exception_unit
        import wb_pkg::*;
(
        input  logic [1:0] i_data_abt,
        input  logic       i_fiq,
        input  logic       i_irq,
        input  logic       i_instr_abt,
        input  logic       i_swi,
        input  logic       i_und,
        input  word_t      i_pc_plus_8,
        input  word_t      i_wr_data,
        input  word_t      i_cpsr,
        output logic       o_active,
        output rf_wr_req_t o_req,
        output redirect_t  o_redirect
);

logic [4:0] mode;
phy_idx_t   r14_idx;
phy_idx_t   spsr_idx;
word_t      vector;
word_t      link;
logic       mask_f;

assign o_active = (|i_data_abt) | i_fiq | i_irq | i_instr_abt | i_swi | i_und;

// Target mode, banked registers and vector of the winning exception.
always_comb
begin
        mode     = MODE_UND;
        r14_idx  = PHY_UND_R14;
        spsr_idx = PHY_UND_SPSR;
        vector   = UND_VECTOR;
        link     = i_wr_data;
        mask_f   = 1'b0;

        if (i_data_abt[0])
        begin
                mode     = MODE_ABT;
                r14_idx  = PHY_ABT_R14;
                spsr_idx = PHY_ABT_SPSR;
                vector   = DABT_VECTOR;
                link     = i_pc_plus_8;
        end
        else if (i_fiq)
        begin
                mode     = MODE_FIQ;
                r14_idx  = PHY_FIQ_R14;
                spsr_idx = PHY_FIQ_SPSR;
                vector   = FIQ_VECTOR;
                mask_f   = 1'b1;
        end
        else if (i_irq)
        begin
                mode     = MODE_IRQ;
                r14_idx  = PHY_IRQ_R14;
                spsr_idx = PHY_IRQ_SPSR;
                vector   = IRQ_VECTOR;
        end
        else if (i_instr_abt)
        begin
                mode     = MODE_ABT;
                r14_idx  = PHY_ABT_R14;
                spsr_idx = PHY_ABT_SPSR;
                vector   = PABT_VECTOR;
        end
        else if (i_swi)
        begin
                mode     = MODE_SVC;
                r14_idx  = PHY_SVC_R14;
                spsr_idx = PHY_SVC_SPSR;
                vector   = SWI_VECTOR;
        end
end

always_comb
begin
        o_req       = '0;
        o_req.idx_a = PHY_RAZ;
        o_req.idx_b = PHY_RAZ;
        o_redirect  = '0;

        if (i_data_abt[1])
        begin
                // Restart the aborted instruction without any write.
                o_redirect.valid = 1'b1;
                o_redirect.pc    = i_pc_plus_8 - 32'd8;
        end
        else if (o_active)
        begin
                o_req.en                     = 1'b1;
                o_req.idx_a                  = r14_idx;
                o_req.data_a                 = link;
                o_req.idx_b                  = spsr_idx;
                o_req.data_b                 = i_cpsr;
                o_req.cpsr_en                = 1'b1;
                o_req.cpsr                   = i_cpsr;
                o_req.cpsr[MODE_HI:MODE_LO]  = mode;
                o_req.cpsr[I_BIT]            = 1'b1;
                if (mask_f)
                begin
                        o_req.cpsr[F_BIT] = 1'b1;
                end
                o_redirect.valid = 1'b1;
                o_redirect.pc    = vector;
        end
end

endmodule

`default_nettype wire

// File: src/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit
        import wb_pkg::*;
(
        input  logic       i_valid,
        input  phy_idx_t   i_wr_index,
        input  word_t      i_wr_data,
        input  logic       i_mem_load,
        input  phy_idx_t   i_wr_index_1,
        input  word_t      i_wr_data_1,
        input  word_t      i_flags,
        output rf_wr_req_t o_req,
        output redirect_t  o_redirect
);

logic load_to_pc;

assign load_to_pc = i_valid && i_mem_load && (i_wr_index_1 == ARCH_PC);

// Port A carries the ALU result, port B the memory result.
always_comb
begin
        o_req.en      = i_valid;
        o_req.idx_a   = i_wr_index;
        o_req.data_a  = i_wr_data;
        o_req.idx_b   = i_mem_load ? i_wr_index_1 : PHY_RAZ;
        o_req.data_b  = i_wr_data_1;
        o_req.cpsr_en = i_valid;
        o_req.cpsr    = i_flags;
end

// A load into the PC flushes the front end.
assign o_redirect.valid = load_to_pc;
assign o_redirect.pc    = i_wr_data_1;

endmodule

`default_nettype wire

// File: src/writeback_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_arbiter
        import wb_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_reset,
        input  logic       i_exc_active,
        input  rf_wr_req_t i_exc_req,
        input  rf_wr_req_t i_retire_req,
        input  logic       i_copro_en,
        input  phy_idx_t   i_copro_wr_index,
        input  word_t      i_copro_wr_data,
        output rf_wr_req_t o_rf_req,
        output word_t      o_cpsr
);

rf_wr_req_t copro_req;
word_t      cpsr_ff;

// Coprocessor writes one register and leaves the flags alone.
always_comb
begin
        copro_req         = '0;
        copro_req.en      = 1'b1;
        copro_req.idx_a   = i_copro_wr_index;
        copro_req.data_a  = i_copro_wr_data;
        copro_req.idx_b   = PHY_RAZ;
        copro_req.cpsr    = cpsr_ff;
end

// ----------------------------------------------------------------------
// Fixed priority grant.
// ----------------------------------------------------------------------

always_comb
begin
        if (i_exc_active)
        begin
                o_rf_req = i_exc_req;
        end
        else if (i_copro_en)
        begin
                o_rf_req = copro_req;
        end
        else
        begin
                o_rf_req = i_retire_req;
        end
end

// CPSR moves on the same edge as the register write.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff <= CPSR_INIT;
        end
        else if (o_rf_req.cpsr_en)
        begin
                cpsr_ff <= o_rf_req.cpsr;
        end
end

assign o_cpsr = cpsr_ff;

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
        import wb_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_reset,
        input  rf_wr_req_t i_req,
        input  phy_idx_t   i_rd_index_0,
        input  phy_idx_t   i_rd_index_1,
        output word_t      o_rd_data_0,
        output word_t      o_rd_data_1
);

word_t mem [PHY_REGS];

// Both ports on one edge; the later assignment lets port B win.
always_ff @(posedge i_clk)
begin
        if (!i_reset && i_req.en)
        begin
                mem[i_req.idx_a] <= i_req.data_a;
                mem[i_req.idx_b] <= i_req.data_b;
        end
end

// Asynchronous read with the zero register forced.
function automatic word_t read_port(input phy_idx_t idx);
        word_t data;
        begin
                data = mem[idx];
                if (idx == PHY_RAZ)
                begin
                        data = '0;
                end
                return data;
        end
endfunction

assign o_rd_data_0 = read_port(i_rd_index_0);
assign o_rd_data_1 = read_port(i_rd_index_1);

endmodule

`default_nettype wire

// File: src/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer
        import wb_pkg::*;
(
        input  logic      i_clk,
        input  logic      i_reset,
        input  logic      i_code_stall,
        input  redirect_t i_exc_redirect,
        input  redirect_t i_retire_redirect,
        input  logic      i_clear_from_alu,
        input  word_t     i_pc_from_alu,
        input  logic      i_clear_from_decode,
        input  word_t     i_pc_from_decode,
        input  logic      i_clear_from_icache,
        output word_t     o_fetch_pc,
        output word_t     o_pc,
        output logic      o_pc_valid,
        output logic      o_clear_from_writeback
);

pc_slot_t pc_ff, pc_nxt;
pc_slot_t del1_ff, del1_nxt;
pc_slot_t del2_ff, del2_nxt;
pc_slot_t del3_ff, del3_nxt;
logic     shelve_ff, shelve_nxt;
word_t    shelve_pc_ff, shelve_pc_nxt;

logic     take;
word_t    target;

assign o_clear_from_writeback = i_exc_redirect.valid | i_retire_redirect.valid;

// Highest priority redirect source.
always_comb
begin
        take   = 1'b1;
        target = i_exc_redirect.pc;
        if (i_exc_redirect.valid)
        begin
                target = i_exc_redirect.pc;
        end
        else if (i_retire_redirect.valid)
        begin
                target = i_retire_redirect.pc;
        end
        else if (i_clear_from_alu)
        begin
                target = i_pc_from_alu;
        end
        else if (i_clear_from_decode)
        begin
                target = i_pc_from_decode;
        end
        else
        begin
                take = 1'b0;
        end
end

// ----------------------------------------------------------------------
// Next state of the fetch PC and delay line.
// ----------------------------------------------------------------------

always_comb
begin
        pc_nxt        = pc_ff;
        del1_nxt      = del1_ff;
        del2_nxt      = del2_ff;
        del3_nxt      = del3_ff;
        shelve_nxt    = shelve_ff;
        shelve_pc_nxt = shelve_pc_ff;

        if (take && i_code_stall)
        begin
                // Park it; a later one replaces it.
                shelve_nxt    = 1'b1;
                shelve_pc_nxt = target;
        end
        else if (take || (!i_code_stall && !shelve_ff && i_clear_from_icache))
        begin
                // Jump. Older stages stay but are invalid.
                pc_nxt     = '{valid: 1'b1, pc: take ? target : del3_ff.pc};
                del1_nxt   = '{valid: 1'b0, pc: pc_ff.pc};
                del2_nxt   = '{valid: 1'b0, pc: del1_ff.pc};
                del3_nxt   = '{valid: 1'b0, pc: del2_ff.pc};
                shelve_nxt = 1'b0;
        end
        else if (i_code_stall)
        begin
                // Hold everything.
                pc_nxt = pc_ff;
        end
        else if (shelve_ff)
        begin
                pc_nxt     = '{valid: 1'b1, pc: shelve_pc_ff};
                del1_nxt   = '0;
                del2_nxt   = '0;
                del3_nxt   = '0;
                shelve_nxt = 1'b0;
        end
        else
        begin
                pc_nxt.pc = pc_ff.pc + 32'd4;
                del1_nxt  = pc_ff;
                del2_nxt  = del1_ff;
                del3_nxt  = del2_ff;
        end

        pc_nxt.pc[0] = 1'b0;
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff     <= '{valid: 1'b1, pc: RESET_VECTOR};
                del1_ff   <= '0;
                del2_ff   <= '0;
                del3_ff   <= '0;
                shelve_ff <= 1'b0;
        end
        else
        begin
                pc_ff     <= pc_nxt;
                del1_ff   <= del1_nxt;
                del2_ff   <= del2_nxt;
                del3_ff   <= del3_nxt;
                shelve_ff <= shelve_nxt;
        end
end

// Shelved target register.
always_ff @(posedge i_clk)
begin
        shelve_pc_ff <= shelve_pc_nxt;
end

assign o_fetch_pc = pc_ff.pc;
assign o_pc       = del3_ff.pc;
assign o_pc_valid = del3_ff.valid;

endmodule

`default_nettype wire

// File: src/writeback_top.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_top
        import wb_pkg::*;
(
        input  logic       i_clk,
        input  logic       i_reset,
        input  logic       i_code_stall,
        input  logic       i_clear_from_alu,
        input  word_t      i_pc_from_alu,
        input  logic       i_clear_from_decode,
        input  word_t      i_pc_from_decode,
        input  logic       i_clear_from_icache,
        input  logic       i_valid,
        input  phy_idx_t   i_wr_index,
        input  word_t      i_wr_data,
        input  logic       i_mem_load,
        input  phy_idx_t   i_wr_index_1,
        input  word_t      i_wr_data_1,
        input  word_t      i_flags,
        input  phy_idx_t   i_rd_index_0,
        input  phy_idx_t   i_rd_index_1,
        input  logic [1:0] i_data_abt,
        input  logic       i_fiq,
        input  logic       i_irq,
        input  logic       i_instr_abt,
        input  logic       i_swi,
        input  logic       i_und,
        input  word_t      i_pc_plus_8,
        input  logic       i_copro_en,
        input  phy_idx_t   i_copro_wr_index,
        input  word_t      i_copro_wr_data,
        output word_t      o_rd_data_0,
        output word_t      o_rd_data_1,
        output word_t      o_cpsr,
        output word_t      o_fetch_pc,
        output word_t      o_pc,
        output logic       o_pc_valid,
        output logic       o_clear_from_writeback
);

logic       exc_active;
rf_wr_req_t exc_req;
rf_wr_req_t retire_req;
rf_wr_req_t rf_req;
redirect_t  exc_redirect;
redirect_t  retire_redirect;

exception_unit exception_unit_i (
        .i_data_abt  (i_data_abt),
        .i_fiq       (i_fiq),
        .i_irq       (i_irq),
        .i_instr_abt (i_instr_abt),
        .i_swi       (i_swi),
        .i_und       (i_und),
        .i_pc_plus_8 (i_pc_plus_8),
        .i_wr_data   (i_wr_data),
        .i_cpsr      (o_cpsr),
        .o_active    (exc_active),
        .o_req       (exc_req),
        .o_redirect  (exc_redirect)
);

retire_unit retire_unit_i (
        .i_valid      (i_valid),
        .i_wr_index   (i_wr_index),
        .i_wr_data    (i_wr_data),
        .i_mem_load   (i_mem_load),
        .i_wr_index_1 (i_wr_index_1),
        .i_wr_data_1  (i_wr_data_1),
        .i_flags      (i_flags),
        .o_req        (retire_req),
        .o_redirect   (retire_redirect)
);

writeback_arbiter writeback_arbiter_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_exc_active     (exc_active),
        .i_exc_req        (exc_req),
        .i_retire_req     (retire_req),
        .i_copro_en       (i_copro_en),
        .i_copro_wr_index (i_copro_wr_index),
        .i_copro_wr_data  (i_copro_wr_data),
        .o_rf_req         (rf_req),
        .o_cpsr           (o_cpsr)
);

register_file register_file_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req        (rf_req),
        .i_rd_index_0 (i_rd_index_0),
        .i_rd_index_1 (i_rd_index_1),
        .o_rd_data_0  (o_rd_data_0),
        .o_rd_data_1  (o_rd_data_1)
);

pc_sequencer pc_sequencer_i (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_exc_redirect         (exc_redirect),
        .i_retire_redirect      (retire_redirect),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_clear_from_icache    (i_clear_from_icache),
        .o_fetch_pc             (o_fetch_pc),
        .o_pc                   (o_pc),
        .o_pc_valid             (o_pc_valid),
        .o_clear_from_writeback (o_clear_from_writeback)
);

endmodule

`default_nettype wire

// File: bench/wb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module wb_checker
        import wb_pkg::*;
(
        input logic       i_clk,
        input logic       i_reset,
        input logic       i_code_stall,
        input logic [1:0] i_data_abt,
        input logic       i_fiq,
        input logic       i_irq,
        input logic       i_instr_abt,
        input logic       i_swi,
        input logic       i_und,
        input word_t      i_cpsr,
        input word_t      i_fetch_pc,
        input logic       i_clear_from_writeback
);

logic exc_entry;

// Any exception except a restart.
assign exc_entry = !i_data_abt[1] &&
                   (i_data_abt[0] || i_fiq || i_irq || i_instr_abt || i_swi || i_und);

// ----------------------------------------------------------------------
// Properties.
// ----------------------------------------------------------------------

clear_low_after_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_clear_from_writeback)
        else $error("clear from writeback high in the cycle after reset");

fetch_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_fetch_pc[0])
        else $error("fetch pc bit 0 set");

irq_masked_on_entry: assert property (@(posedge i_clk) disable iff (i_reset)
        exc_entry |=> i_cpsr[I_BIT])
        else $error("I bit clear after exception entry");

fetch_pc_frozen: assert property (@(posedge i_clk) disable iff (i_reset)
        i_code_stall |=> $stable(i_fetch_pc))
        else $error("fetch pc moved during code stall");

endmodule

bind writeback_top wb_checker wb_checker_i (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_data_abt             (i_data_abt),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_instr_abt            (i_instr_abt),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_cpsr                 (o_cpsr),
        .i_fetch_pc             (o_fetch_pc),
        .i_clear_from_writeback (o_clear_from_writeback)
);

`default_nettype wire

// File: bench/tb_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module tb_writeback
        import wb_pkg::*;
();

logic       i_clk;
logic       i_reset;
logic       i_code_stall;
logic       i_clear_from_alu;
word_t      i_pc_from_alu;
logic       i_clear_from_decode;
word_t      i_pc_from_decode;
logic       i_clear_from_icache;
logic       i_valid;
phy_idx_t   i_wr_index;
word_t      i_wr_data;
logic       i_mem_load;
phy_idx_t   i_wr_index_1;
word_t      i_wr_data_1;
word_t      i_flags;
phy_idx_t   i_rd_index_0;
phy_idx_t   i_rd_index_1;
logic [1:0] i_data_abt;
logic       i_fiq;
logic       i_irq;
logic       i_instr_abt;
logic       i_swi;
logic       i_und;
word_t      i_pc_plus_8;
logic       i_copro_en;
phy_idx_t   i_copro_wr_index;
word_t      i_copro_wr_data;
word_t      o_rd_data_0;
word_t      o_rd_data_1;
word_t      o_cpsr;
word_t      o_fetch_pc;
word_t      o_pc;
logic       o_pc_valid;
logic       o_clear_from_writeback;

integer     seed;
int         errors;
int         tests_run;
int         tests_failed;
word_t      irq_link;

writeback_top dut_i (.*);

initial
begin
        i_clk = 1'b0;
        forever
        begin
                #10 i_clk = ~i_clk;
        end
end

// ----------------------------------------------------------------------
// Helpers.
// ----------------------------------------------------------------------

task automatic drive_idle();
        i_code_stall        = 1'b0;
        i_clear_from_alu    = 1'b0;
        i_pc_from_alu       = '0;
        i_clear_from_decode = 1'b0;
        i_pc_from_decode    = '0;
        i_clear_from_icache = 1'b0;
        i_valid             = 1'b0;
        i_wr_index          = '0;
        i_wr_data           = '0;
        i_mem_load          = 1'b0;
        i_wr_index_1        = '0;
        i_wr_data_1         = '0;
        i_flags             = '0;
        i_data_abt          = 2'b00;
        i_fiq               = 1'b0;
        i_irq               = 1'b0;
        i_instr_abt         = 1'b0;
        i_swi               = 1'b0;
        i_und               = 1'b0;
        i_pc_plus_8         = '0;
        i_copro_en          = 1'b0;
        i_copro_wr_index    = '0;
        i_copro_wr_data     = '0;
endtask

task automatic expect_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
                $display("FAILED %s: expected 0x%08h, got 0x%08h", name, exp, got);
                errors++;
        end
endtask

task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
                $display("FAILED %s: expected 0x%0h, got 0x%0h", name, exp, got);
                errors++;
        end
endtask

task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
        begin
                $display("test %s: ok", name);
        end
        else
        begin
                tests_failed++;
                $display("test %s: %0d errors", name, errors - start_errors);
        end
endtask

// Counts advancing cycles until the oldest delay stage is valid.
task automatic wait_pc_valid(output int cycles);
        cycles = 0;
        while (!o_pc_valid && cycles < 20)
        begin
                @(negedge i_clk);
                cycles++;
        end
        if (!o_pc_valid)
        begin
                $display("Timed out waiting for o_pc_valid to rise");
                errors++;
        end
endtask

// Mode replaced, IRQ masked, FIQ masked on request.
function automatic word_t entry_cpsr(input word_t prev, input logic [4:0] mode,
                                     input logic set_f);
        word_t cpsr;
        cpsr        = prev;
        cpsr[4:0]   = mode;
        cpsr[I_BIT] = 1'b1;
        if (set_f)
        begin
                cpsr[F_BIT] = 1'b1;
        end
        return cpsr;
endfunction

// ----------------------------------------------------------------------
// Tests.
// ----------------------------------------------------------------------

task automatic test_sequential_fetch();
        int start;
        int cycles;
        start = errors;
        expect_word("o_fetch_pc", o_fetch_pc, RESET_VECTOR);
        expect_bit("o_pc_valid", o_pc_valid, 1'b0);
        expect_bit("o_clear_from_writeback", o_clear_from_writeback, 1'b0);
        expect_word("o_cpsr", o_cpsr, CPSR_INIT);
        wait_pc_valid(cycles);
        expect_word("advance count", word_t'(cycles), 32'd3);
        expect_word("o_fetch_pc", o_fetch_pc, RESET_VECTOR + 32'd4 * word_t'(cycles));
        expect_word("o_pc", o_pc, RESET_VECTOR);
        finish_test("sequential fetch", start);
endtask

task automatic test_retire_and_load_pc();
        int    start;
        word_t alu_data;
        word_t load_data;
        word_t flags;
        word_t rnd;
        start     = errors;
        alu_data  = $random(seed);
        load_data = $random(seed);
        rnd       = $random(seed);
        // User mode with both interrupts unmasked.
        flags     = {rnd[31:28], 28'h0000010};
        @(negedge i_clk);
        i_valid      = 1'b1;
        i_wr_index   = 6'd3;
        i_wr_data    = alu_data;
        i_mem_load   = 1'b1;
        i_wr_index_1 = 6'd4;
        i_wr_data_1  = load_data;
        i_flags      = flags;
        @(negedge i_clk);
        drive_idle();
        i_rd_index_0 = 6'd3;
        i_rd_index_1 = 6'd4;
        #1;
        expect_word("o_rd_data_0", o_rd_data_0, alu_data);
        expect_word("o_rd_data_1", o_rd_data_1, load_data);
        expect_word("o_cpsr", o_cpsr, flags);

        // Load into the PC with an odd address.
        load_data = $random(seed);
        load_data = load_data | 32'h1;
        @(negedge i_clk);
        i_valid      = 1'b1;
        i_wr_index   = 6'd5;
        i_wr_data    = alu_data;
        i_mem_load   = 1'b1;
        i_wr_index_1 = ARCH_PC;
        i_wr_data_1  = load_data;
        i_flags      = flags;
        #1;
        expect_bit("o_clear_from_writeback", o_clear_from_writeback, 1'b1);
        @(negedge i_clk);
        drive_idle();
        #1;
        expect_word("o_fetch_pc", o_fetch_pc, load_data & 32'hFFFF_FFFE);
        expect_bit("o_clear_from_writeback", o_clear_from_writeback, 1'b0);
        finish_test("retire and load to pc", start);
endtask

task automatic test_irq_entry();
        int    start;
        word_t prev;
        start    = errors;
        irq_link = $random(seed);
        @(negedge i_clk);
        prev      = o_cpsr;
        i_irq     = 1'b1;
        i_wr_data = irq_link;
        #1;
        expect_bit("o_clear_from_writeback", o_clear_from_writeback, 1'b1);
        @(negedge i_clk);
        drive_idle();
        i_rd_index_0 = PHY_IRQ_R14;
        i_rd_index_1 = PHY_IRQ_SPSR;
        #1;
        expect_word("irq r14", o_rd_data_0, irq_link);
        expect_word("irq spsr", o_rd_data_1, prev);
        expect_word("o_cpsr", o_cpsr, entry_cpsr(prev, MODE_IRQ, 1'b0));
        expect_word("o_fetch_pc", o_fetch_pc, IRQ_VECTOR);
        finish_test("irq entry", start);
endtask

task automatic test_exception_priority();
        int    start;
        word_t prev;
        word_t fiq_link;
        word_t abt_pc;
        start    = errors;
        fiq_link = $random(seed);
        abt_pc   = $random(seed);
        abt_pc[1:0] = 2'b00;

        // FIQ beats IRQ.
        @(negedge i_clk);
        prev      = o_cpsr;
        i_fiq     = 1'b1;
        i_irq     = 1'b1;
        i_wr_data = fiq_link;
        @(negedge i_clk);
        drive_idle();
        i_rd_index_0 = PHY_FIQ_R14;
        i_rd_index_1 = PHY_IRQ_R14;
        #1;
        expect_word("fiq r14", o_rd_data_0, fiq_link);
        expect_word("irq r14", o_rd_data_1, irq_link);
        expect_word("o_cpsr", o_cpsr, entry_cpsr(prev, MODE_FIQ, 1'b1));
        expect_word("o_fetch_pc", o_fetch_pc, FIQ_VECTOR);

        // Data abort links the pc plus 8.
        @(negedge i_clk);
        prev        = o_cpsr;
        i_data_abt  = 2'b01;
        i_pc_plus_8 = abt_pc;
        i_wr_data   = $random(seed);
        @(negedge i_clk);
        drive_idle();
        i_rd_index_0 = PHY_ABT_R14;
        i_rd_index_1 = PHY_ABT_SPSR;
        #1;
        expect_word("abt r14", o_rd_data_0, abt_pc);
        expect_word("abt spsr", o_rd_data_1, prev);
        expect_word("o_cpsr", o_cpsr, entry_cpsr(prev, MODE_ABT, 1'b0));
        expect_word("o_fetch_pc", o_fetch_pc, DABT_VECTOR);

        // Restart writes nothing.
        @(negedge i_clk);
        prev         = o_cpsr;
        i_data_abt   = 2'b10;
        i_pc_plus_8  = 32'h0000_0108;
        i_wr_data    = $random(seed);
        i_rd_index_0 = PHY_ABT_R14;
        i_rd_index_1 = PHY_FIQ_R14;
        #1;
        expect_bit("o_clear_from_writeback", o_clear_from_writeback, 1'b1);
        @(negedge i_clk);
        drive_idle();
        #1;
        expect_word("abt r14", o_rd_data_0, abt_pc);
        expect_word("fiq r14", o_rd_data_1, fiq_link);
        expect_word("o_cpsr", o_cpsr, prev);
        expect_word("o_fetch_pc", o_fetch_pc, 32'h0000_0100);
        finish_test("exception priority", start);
endtask

task automatic test_write_arbitration();
        int    start;
        word_t first;
        word_t second;
        word_t copro;
        word_t cpsr_before;
        start  = errors;
        first  = $random(seed);
        second = $random(seed);
        copro  = $random(seed);
        @(negedge i_clk);
        i_valid    = 1'b1;
        i_wr_index = 6'd7;
        i_wr_data  = first;
        i_flags    = o_cpsr;
        @(negedge i_clk);
        cpsr_before      = o_cpsr;
        i_wr_data        = second;
        i_flags          = cpsr_before ^ 32'hF000_0000;
        i_copro_en       = 1'b1;
        i_copro_wr_index = 6'd8;
        i_copro_wr_data  = copro;
        @(negedge i_clk);
        drive_idle();
        i_rd_index_0 = 6'd7;
        i_rd_index_1 = 6'd8;
        #1;
        expect_word("retire target r7", o_rd_data_0, first);
        expect_word("copro target r8", o_rd_data_1, copro);
        expect_word("o_cpsr", o_cpsr, cpsr_before);
        finish_test("write arbitration", start);
endtask

task automatic test_stall_shelving();
        int    start;
        int    cycles;
        word_t frozen;
        start = errors;
        @(negedge i_clk);
        i_code_stall = 1'b1;
        frozen       = o_fetch_pc;
        @(negedge i_clk);
        i_clear_from_alu = 1'b1;
        i_pc_from_alu    = 32'h0000_0200;
        @(negedge i_clk);
        i_clear_from_alu = 1'b0;
        expect_word("o_fetch_pc", o_fetch_pc, frozen);
        @(negedge i_clk);
        i_code_stall = 1'b0;
        expect_word("o_fetch_pc", o_fetch_pc, frozen);
        @(negedge i_clk);
        expect_word("o_fetch_pc", o_fetch_pc, 32'h0000_0200);

        // Replay the oldest pc once it is valid.
        wait_pc_valid(cycles);
        expect_word("advance count", word_t'(cycles), 32'd3);
        expect_word("o_pc", o_pc, 32'h0000_0200);
        i_clear_from_icache = 1'b1;
        @(negedge i_clk);
        i_clear_from_icache = 1'b0;
        expect_word("o_fetch_pc", o_fetch_pc, 32'h0000_0200);
        finish_test("stall shelving", start);
endtask

// ----------------------------------------------------------------------
// Main sequence.
// ----------------------------------------------------------------------

initial
begin
        seed         = 60;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        irq_link     = '0;
        drive_idle();
        i_rd_index_0 = '0;
        i_rd_index_1 = '0;
        i_reset      = 1'b1;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;

        test_sequential_fetch();
        test_retire_and_load_pc();
        test_irq_entry();
        test_exception_priority();
        test_write_arbitration();
        test_stall_shelving();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
                $display("Finished with no errors");
        end
        else
        begin
                $display("Finished with errors");
        end
        $finish;
end

endmodule

`default_nettype wire

// File: compile.f
src/wb_pkg.sv
src/exception_unit.sv
src/retire_unit.sv
src/writeback_arbiter.sv
src/register_file.sv
src/pc_sequencer.sv
src/writeback_top.sv
bench/wb_checker.sv
bench/tb_writeback.sv

// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
TOP        := tb_writeback
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
